/* verilog/trig_pkg.sv */
package trig_pkg;

	localparam int SAMPLE_W     = 12; // signed adc sample width
	localparam int N_LANES      = 4;  // interleaved adc lanes
	localparam int LANE_SAMPLES = 10; // samples per lane per clklvds
	localparam int ADDR_W       = 10; // ram write address wraps at 1024
	localparam int LEN_W        = 16; // pre and post sample counts
	localparam int DS_W         = 5;  // downsample exponent
	localparam int MERGE_W      = 8;  // merging factor

	// acquisition state codes fixed by the read-out software
	typedef enum logic [7:0] {
		ST_IDLE      = 8'd0,   // latch trigger type while not writing
		ST_ARM       = 8'd1,   // threshold first step
		ST_FIRE      = 8'd2,   // threshold second step
		ST_LVDS_WAIT = 8'd5,   // wait for neighbour board
		ST_AUTO      = 8'd6,   // forced capture
		ST_EXT_WAIT  = 8'd7,   // wait for back-panel input
		ST_PRE       = 8'd249, // pre-trigger samples
		ST_POST      = 8'd250, // post-trigger samples
		ST_DONE      = 8'd251  // hold for read-out
	} acq_state_t;

	// trigger type codes as written by the control interface
	localparam logic [7:0] TRIG_OFF     = 8'd0; // no capture
	localparam logic [7:0] TRIG_RISING  = 8'd1; // low then high edge
	localparam logic [7:0] TRIG_FALLING = 8'd2; // high then low edge
	localparam logic [7:0] TRIG_LVDS    = 8'd3; // from other boards
	localparam logic [7:0] TRIG_AUTO    = 8'd4; // unconditional
	localparam logic [7:0] TRIG_EXT     = 8'd5; // back-panel sma

endpackage

/* verilog/config_regs.sv */
`timescale 1ns/100ps

module config_regs import trig_pkg::*; (
	input  logic                       clklvds,
	input  logic                       rstn,
	input  logic signed [SAMPLE_W-1:0] lowerthresh,
	input  logic signed [SAMPLE_W-1:0] upperthresh,
	input  logic        [LEN_W-1:0]    lengthtotake,
	input  logic        [LEN_W-1:0]    prelengthtotake,
	input  logic                       triggerlive,
	input  logic                       didreadout,
	input  logic        [7:0]          triggertype,
	input  logic        [DS_W-1:0]     downsample,
	input  logic        [MERGE_W-1:0]  downsamplemerging,
	output logic signed [SAMPLE_W-1:0] lowerthresh_q,
	output logic signed [SAMPLE_W-1:0] upperthresh_q,
	output logic        [LEN_W-1:0]    lengthtotake_q,
	output logic        [LEN_W-1:0]    prelengthtotake_q,
	output logic                       triggerlive_q,
	output logic                       didreadout_q,
	output logic        [7:0]          triggertype_q,
	output logic        [DS_W-1:0]     downsample_q,
	output logic        [MERGE_W-1:0]  downsamplemerging_q
);

	// quasi static control domain settings take one register stage into clklvds
	always_ff @(posedge clklvds or negedge rstn) begin
		if (!rstn) begin
			lowerthresh_q       <= '0;
			upperthresh_q       <= '0;
			lengthtotake_q      <= '0;
			prelengthtotake_q   <= '0;
			triggerlive_q       <= 1'b0;
			didreadout_q        <= 1'b0;
			triggertype_q       <= TRIG_OFF; // nothing armed out of reset
			downsample_q        <= '0;
			downsamplemerging_q <= '0;
		end else begin
			lowerthresh_q       <= lowerthresh;
			upperthresh_q       <= upperthresh;
			lengthtotake_q      <= lengthtotake;
			prelengthtotake_q   <= prelengthtotake;
			triggerlive_q       <= triggerlive;       // software allows triggering
			didreadout_q        <= didreadout;        // software finished reading ram
			triggertype_q       <= triggertype;
			downsample_q        <= downsample;        // log2 of clock division
			downsamplemerging_q <= downsamplemerging; // must be 1 or more
		end
	end

endmodule

/* verilog/decimator.sv */
`timescale 1ns/100ps

module decimator import trig_pkg::*; (
	input  logic               clklvds,
	input  logic               rstn,
	input  logic               capture_en,
	input  logic [DS_W-1:0]    downsample_q,
	input  logic [MERGE_W-1:0] downsamplemerging_q,
	output logic               ram_wr,
	output logic [ADDR_W-1:0]  ram_wr_address
);

	localparam int DS_CNT_W = 1 << DS_W; // one bit per possible downsample setting

	logic [DS_CNT_W-1:0] ds_cnt;    // counts 1 .. 2^downsample
	logic [MERGE_W-1:0]  merge_cnt; // counts downsample ticks up to merging
	logic                ds_tick;   // one clock in 2^downsample

	assign ds_tick = ds_cnt[downsample_q]; // bit reached when count hits 2^downsample

	always_ff @(posedge clklvds or negedge rstn) begin
		if (!rstn) begin
			ds_cnt         <= DS_CNT_W'(1);
			merge_cnt      <= MERGE_W'(1);
			ram_wr         <= 1'b0;
			ram_wr_address <= '0;
		end else if (!capture_en) begin
			ds_cnt    <= DS_CNT_W'(1); // hold both counters at their start
			merge_cnt <= MERGE_W'(1);
			ram_wr    <= 1'b0;         // address kept since the ram is a ring
		end else if (ds_tick) begin
			ds_cnt <= DS_CNT_W'(1);
			if (merge_cnt == downsamplemerging_q) begin
				merge_cnt      <= MERGE_W'(1);
				ram_wr_address <= ram_wr_address + 1'b1; // wraps at 2^ADDR_W
				ram_wr         <= 1'b1;                  // one merged sample ready
			end else begin
				merge_cnt <= merge_cnt + 1'b1;
				ram_wr    <= 1'b0;
			end
		end else begin
			ds_cnt <= ds_cnt + 1'b1;
			ram_wr <= 1'b0;
		end
	end

endmodule

/* verilog/threshold_lane.sv */
`timescale 1ns/100ps

module threshold_lane import trig_pkg::*; #(
	parameter int LANE_SAMPLES = trig_pkg::LANE_SAMPLES
) (
	input  logic                       clklvds,
	input  logic                       rstn,
	input  logic signed [SAMPLE_W-1:0] samples [LANE_SAMPLES],
	input  logic signed [SAMPLE_W-1:0] lowerthresh_q,
	input  logic signed [SAMPLE_W-1:0] upperthresh_q,
	input  logic                       rising,
	output logic                       arm_hit,
	output logic                       fire_hit
);

	logic any_below; // some sample under the lower threshold
	logic any_above; // some sample over the upper threshold

	always_comb begin
		any_below = 1'b0;
		any_above = 1'b0;
		for (int i = 0; i < LANE_SAMPLES; i++) begin
			if (samples[i] < lowerthresh_q)
				any_below = 1'b1; // signed compare
			if (samples[i] > upperthresh_q)
				any_above = 1'b1;
		end
	end

	// rising edge arms low and fires high, falling edge the other way round
	always_ff @(posedge clklvds or negedge rstn) begin
		if (!rstn) begin
			arm_hit  <= 1'b0;
			fire_hit <= 1'b0;
		end else begin
			arm_hit  <= rising ? any_below : any_above;
			fire_hit <= rising ? any_above : any_below;
		end
	end

endmodule

/* verilog/acq_controller.sv */
`timescale 1ns/100ps

module acq_controller import trig_pkg::*; (
	input  logic              clklvds,
	input  logic              rstn,
	input  logic [7:0]        triggertype_q,
	input  logic              triggerlive_q,
	input  logic              didreadout_q,
	input  logic [LEN_W-1:0]  lengthtotake_q,
	input  logic [LEN_W-1:0]  prelengthtotake_q,
	input  logic              ram_wr,
	input  logic [ADDR_W-1:0] ram_wr_address,
	input  logic              any_arm,
	input  logic              any_fire,
	input  logic              lvdsin_trig,
	input  logic              lvdsin_trig_b,
	input  logic              exttrigin,
	output logic              capture_en,
	output logic              rising,
	output acq_state_t        acq_state,
	output logic [31:0]       event_count,
	output logic [ADDR_W-1:0] ram_address_triggered,
	output logic              lvdsout_trig,
	output logic              lvdsout_trig_b,
	output logic              auxtrigout
);

	logic [7:0]       cur_type;     // type latched when leaving idle
	logic [LEN_W-1:0] sample_cnt;   // write strobes seen in pre or post
	logic [LEN_W:0]   post_next;    // post count including this cycle's strobe
	logic             lvds_hold;    // keeps the lvds pulse up for its second cycle
	logic             waiting;      // states that abort on a type change
	logic             type_changed;
	logic             fwd_set;      // trigger to forward to the next board
	logic             bwd_set;      // trigger to pass back to the previous board
	logic             trig_now;

	assign capture_en   = (acq_state != ST_IDLE) && (acq_state != ST_DONE);
	assign auxtrigout   = (acq_state == ST_POST); // back-panel gate spans post-trigger
	assign rising       = (cur_type == TRIG_RISING);
	assign type_changed = (triggertype_q != cur_type);
	assign post_next    = sample_cnt + ram_wr;
	assign trig_now     = fwd_set || bwd_set;

	always_comb begin
		waiting = 1'b0;
		fwd_set = 1'b0;
		bwd_set = 1'b0;
		case (acq_state)
			ST_PRE, ST_ARM: waiting = 1'b1;
			ST_FIRE: begin
				waiting = 1'b1;
				fwd_set = any_fire; // locally seen edge goes both ways
				bwd_set = any_fire;
			end
			ST_AUTO: begin
				waiting = 1'b1;
				fwd_set = 1'b1;
				bwd_set = 1'b1;
			end
			ST_LVDS_WAIT: begin
				waiting = 1'b1;
				fwd_set = lvdsin_trig;   // keep travelling in the same direction
				bwd_set = lvdsin_trig_b;
			end
			ST_EXT_WAIT: begin
				waiting = 1'b1;
				fwd_set = exttrigin;
				bwd_set = exttrigin;
			end
			default: waiting = 1'b0;
		endcase
	end

	always_ff @(posedge clklvds or negedge rstn) begin
		if (!rstn) begin
			acq_state             <= ST_IDLE;
			cur_type              <= TRIG_OFF;
			sample_cnt            <= '0;
			lvds_hold             <= 1'b0;
			event_count           <= '0;
			ram_address_triggered <= '0;
			lvdsout_trig          <= 1'b0;
			lvdsout_trig_b        <= 1'b0;
		end else if (waiting && type_changed) begin
			acq_state <= ST_IDLE; // software changed its mind so start over
		end else if (trig_now) begin
			ram_address_triggered <= ram_wr_address; // where the event sits in the ring
			lvdsout_trig          <= fwd_set;
			lvdsout_trig_b        <= bwd_set;
			lvds_hold             <= 1'b1;
			sample_cnt            <= '0;
			acq_state             <= ST_POST;
		end else begin
			case (acq_state)
				ST_IDLE: begin
					cur_type       <= triggertype_q;
					sample_cnt     <= '0;
					lvdsout_trig   <= 1'b0;
					lvdsout_trig_b <= 1'b0;
					if (triggertype_q != TRIG_OFF)
						acq_state <= ST_PRE;
				end
				ST_PRE: begin
					if (sample_cnt < prelengthtotake_q) begin
						if (ram_wr)
							sample_cnt <= sample_cnt + 1'b1; // fill pre-trigger history
					end else if (triggerlive_q) begin
						sample_cnt <= '0; // reused for the post count
						case (cur_type)
							TRIG_RISING, TRIG_FALLING: acq_state <= ST_ARM;
							TRIG_LVDS:                 acq_state <= ST_LVDS_WAIT;
							TRIG_AUTO:                 acq_state <= ST_AUTO;
							TRIG_EXT:                  acq_state <= ST_EXT_WAIT;
							default:                   acq_state <= ST_IDLE; // unknown code
						endcase
					end
				end
				ST_ARM: begin
					if (any_arm)
						acq_state <= ST_FIRE; // first step of the edge met
				end
				ST_FIRE, ST_LVDS_WAIT, ST_AUTO, ST_EXT_WAIT: begin
					acq_state <= acq_state; // no trigger yet
				end
				ST_POST: begin
					if (lvds_hold)
						lvds_hold <= 1'b0;
					else begin
						lvdsout_trig   <= 1'b0; // pulse lasted two cycles
						lvdsout_trig_b <= 1'b0;
					end
					if (post_next >= lengthtotake_q) begin
						event_count <= event_count + 1'b1;
						acq_state   <= ST_DONE;
					end else begin
						sample_cnt <= post_next[LEN_W-1:0];
					end
				end
				ST_DONE: begin
					lvdsout_trig   <= 1'b0;
					lvdsout_trig_b <= 1'b0;
					sample_cnt     <= '0;
					if (didreadout_q)
						acq_state <= ST_IDLE; // ram read out and ready for the next event
				end
				default: acq_state <= ST_IDLE;
			endcase
		end
	end

endmodule

/* verilog/triggerer.sv */
`timescale 1ns/100ps

module triggerer import trig_pkg::*; #(
	parameter int N_LANES      = trig_pkg::N_LANES,
	parameter int LANE_SAMPLES = trig_pkg::LANE_SAMPLES
) (
	input  logic                       clklvds,
	input  logic                       rstn,
	input  logic signed [SAMPLE_W-1:0] samplevalue [N_LANES*LANE_SAMPLES],
	input  logic                       lvdsin_trig,
	input  logic                       lvdsin_trig_b,
	input  logic                       exttrigin,
	input  logic signed [SAMPLE_W-1:0] lowerthresh,
	input  logic signed [SAMPLE_W-1:0] upperthresh,
	input  logic        [LEN_W-1:0]    lengthtotake,
	input  logic        [LEN_W-1:0]    prelengthtotake,
	input  logic                       triggerlive,
	input  logic                       didreadout,
	input  logic        [7:0]          triggertype,
	input  logic        [DS_W-1:0]     downsample,
	input  logic        [MERGE_W-1:0]  downsamplemerging,
	output logic                       ram_wr,
	output logic        [ADDR_W-1:0]   ram_wr_address,
	output logic                       lvdsout_trig,
	output logic                       lvdsout_trig_b,
	output logic                       auxtrigout,
	output logic                       led,
	output acq_state_t                 acq_state,
	output logic        [31:0]         event_count,
	output logic        [ADDR_W-1:0]   ram_address_triggered
);

	logic signed [SAMPLE_W-1:0] lowerthresh_q;
	logic signed [SAMPLE_W-1:0] upperthresh_q;
	logic        [LEN_W-1:0]    lengthtotake_q;
	logic        [LEN_W-1:0]    prelengthtotake_q;
	logic                       triggerlive_q;
	logic                       didreadout_q;
	logic        [7:0]          triggertype_q;
	logic        [DS_W-1:0]     downsample_q;
	logic        [MERGE_W-1:0]  downsamplemerging_q;
	logic                       capture_en;
	logic                       rising;
	logic        [N_LANES-1:0]  arm_hits;  // one bit per lane
	logic        [N_LANES-1:0]  fire_hits;

	assign led = exttrigin; // front led echoes the back-panel input

	config_regs u_config_regs (
		.clklvds(clklvds), .rstn(rstn),
		.lowerthresh(lowerthresh), .upperthresh(upperthresh),
		.lengthtotake(lengthtotake), .prelengthtotake(prelengthtotake),
		.triggerlive(triggerlive), .didreadout(didreadout),
		.triggertype(triggertype), .downsample(downsample),
		.downsamplemerging(downsamplemerging),
		.lowerthresh_q(lowerthresh_q), .upperthresh_q(upperthresh_q),
		.lengthtotake_q(lengthtotake_q), .prelengthtotake_q(prelengthtotake_q),
		.triggerlive_q(triggerlive_q), .didreadout_q(didreadout_q),
		.triggertype_q(triggertype_q), .downsample_q(downsample_q),
		.downsamplemerging_q(downsamplemerging_q)
	);

	decimator u_decimator (
		.clklvds(clklvds), .rstn(rstn), .capture_en(capture_en),
		.downsample_q(downsample_q), .downsamplemerging_q(downsamplemerging_q),
		.ram_wr(ram_wr), .ram_wr_address(ram_wr_address)
	);

	for (genvar g = 0; g < N_LANES; g++) begin : g_lane
		logic signed [SAMPLE_W-1:0] lane_samples [LANE_SAMPLES]; // this lane's slice
		for (genvar j = 0; j < LANE_SAMPLES; j++) begin : g_slice
			assign lane_samples[j] = samplevalue[g*LANE_SAMPLES + j];
		end
		threshold_lane #(.LANE_SAMPLES(LANE_SAMPLES)) u_lane (
			.clklvds(clklvds), .rstn(rstn), .samples(lane_samples),
			.lowerthresh_q(lowerthresh_q), .upperthresh_q(upperthresh_q),
			.rising(rising), .arm_hit(arm_hits[g]), .fire_hit(fire_hits[g])
		);
	end

	acq_controller u_acq_controller (
		.clklvds(clklvds), .rstn(rstn),
		.triggertype_q(triggertype_q), .triggerlive_q(triggerlive_q),
		.didreadout_q(didreadout_q), .lengthtotake_q(lengthtotake_q),
		.prelengthtotake_q(prelengthtotake_q),
		.ram_wr(ram_wr), .ram_wr_address(ram_wr_address),
		.any_arm(|arm_hits), .any_fire(|fire_hits), // any lane may carry the edge
		.lvdsin_trig(lvdsin_trig), .lvdsin_trig_b(lvdsin_trig_b), .exttrigin(exttrigin),
		.capture_en(capture_en), .rising(rising), .acq_state(acq_state),
		.event_count(event_count), .ram_address_triggered(ram_address_triggered),
		.lvdsout_trig(lvdsout_trig), .lvdsout_trig_b(lvdsout_trig_b),
		.auxtrigout(auxtrigout)
	);

endmodule

/* sim/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam logic [2:0] PAT_QUIET = 3'd0; // noise between the thresholds only
localparam logic [2:0] PAT_LOHI  = 3'd1; // low then high on one lane
localparam logic [2:0] PAT_HILO  = 3'd2; // high then low on one lane
localparam logic [2:0] PAT_HI    = 3'd3; // high only so a rising edge never arms
localparam logic [2:0] PAT_LO    = 3'd4; // low only so a falling edge never arms

localparam logic [1:0] PULSE_NONE = 2'd0;
localparam logic [1:0] PULSE_FWD  = 2'd1; // lvdsin_trig
localparam logic [1:0] PULSE_BWD  = 2'd2; // lvdsin_trig_b
localparam logic [1:0] PULSE_EXT  = 2'd3; // exttrigin

typedef struct packed {
	logic [7:0]  ttype;     // triggertype
	logic [4:0]  ds;        // downsample exponent
	logic [7:0]  merge;     // downsamplemerging
	logic [15:0] pre;       // prelengthtotake
	logic [15:0] post;      // lengthtotake
	logic [2:0]  pattern;   // sample pattern
	logic [1:0]  lane;      // lane that carries the crossing
	logic [1:0]  pulse;     // lvds or external pulse
	logic        exp_event; // one event expected
	logic [1:0]  exp_lvds;  // bit 0 forward output pulses and bit 1 backward
} vec_t;

localparam int N_TESTS = 11;

// type, ds, merge, pre, post, pattern, lane, pulse, event, lvds
localparam vec_t VECTORS [N_TESTS] = '{
	'{TRIG_OFF,     5'd0, 8'd1, 16'd4, 16'd4, PAT_QUIET, 2'd0, PULSE_NONE, 1'b0, 2'b00},
	'{TRIG_AUTO,    5'd0, 8'd1, 16'd4, 16'd6, PAT_QUIET, 2'd0, PULSE_NONE, 1'b1, 2'b11},
	'{TRIG_AUTO,    5'd2, 8'd3, 16'd3, 16'd5, PAT_QUIET, 2'd0, PULSE_NONE, 1'b1, 2'b11},
	'{TRIG_RISING,  5'd1, 8'd1, 16'd4, 16'd8, PAT_LOHI,  2'd0, PULSE_NONE, 1'b1, 2'b11},
	'{TRIG_RISING,  5'd0, 8'd2, 16'd2, 16'd4, PAT_HI,    2'd1, PULSE_NONE, 1'b0, 2'b00},
	'{TRIG_FALLING, 5'd0, 8'd1, 16'd4, 16'd6, PAT_HILO,  2'd2, PULSE_NONE, 1'b1, 2'b11},
	'{TRIG_FALLING, 5'd1, 8'd2, 16'd2, 16'd4, PAT_LO,    2'd3, PULSE_NONE, 1'b0, 2'b00},
	'{TRIG_LVDS,    5'd0, 8'd1, 16'd4, 16'd5, PAT_QUIET, 2'd0, PULSE_FWD,  1'b1, 2'b01},
	'{TRIG_LVDS,    5'd1, 8'd1, 16'd3, 16'd4, PAT_QUIET, 2'd0, PULSE_BWD,  1'b1, 2'b10},
	'{TRIG_EXT,     5'd0, 8'd3, 16'd4, 16'd5, PAT_QUIET, 2'd0, PULSE_EXT,  1'b1, 2'b11},
	'{TRIG_LVDS,    5'd0, 8'd1, 16'd2, 16'd4, PAT_QUIET, 2'd0, PULSE_NONE, 1'b0, 2'b00}
};

`endif

/* sim/tb_triggerer.sv */
`timescale 1ns/100ps

module tb_triggerer import trig_pkg::*; ();

	logic                       clklvds;
	logic                       rstn;
	logic signed [SAMPLE_W-1:0] samplevalue [N_LANES*LANE_SAMPLES];
	logic                       lvdsin_trig;
	logic                       lvdsin_trig_b;
	logic                       exttrigin;
	logic signed [SAMPLE_W-1:0] lowerthresh;
	logic signed [SAMPLE_W-1:0] upperthresh;
	logic        [LEN_W-1:0]    lengthtotake;
	logic        [LEN_W-1:0]    prelengthtotake;
	logic                       triggerlive;
	logic                       didreadout;
	logic        [7:0]          triggertype;
	logic        [DS_W-1:0]     downsample;
	logic        [MERGE_W-1:0]  downsamplemerging;
	logic                       ram_wr;
	logic        [ADDR_W-1:0]   ram_wr_address;
	logic                       lvdsout_trig;
	logic                       lvdsout_trig_b;
	logic                       auxtrigout;
	logic                       led;
	acq_state_t                 acq_state;
	logic        [31:0]         event_count;
	logic        [ADDR_W-1:0]   ram_address_triggered;

	`include "tb_vectors.svh"

	int                         cycle;              // clocks since start
	int                         limit;              // timeout in cycles
	int                         errors       = 0;
	int                         passed       = 0;
	int                         failed       = 0;
	int                         fwd_cycles   = 0;   // cycles with lvdsout_trig high
	int                         bwd_cycles   = 0;
	int                         aux_pulses   = 0;   // ram_wr seen while auxtrigout high
	int                         spacing      = 1;   // expected ram_wr period of this row
	int                         last_pulse   = -1;  // cycle of previous ram_wr or -1
	int                         err_before;
	int                         fwd_before;
	int                         bwd_before;
	int                         aux_before;
	logic        [ADDR_W-1:0]   exp_addr     = '0;  // ring address after the last strobe
	logic        [ADDR_W-1:0]   prev_addr    = '0;  // expected address one cycle back
	acq_state_t                 prev_state   = ST_IDLE;
	logic        [31:0]         exp_events   = '0;  // events the table asked for so far
	logic signed [SAMPLE_W-1:0] forced_level = '0;  // 0 means noise only
	logic        [1:0]          forced_lane  = '0;
	vec_t                       v;

	triggerer u_triggerer (
		.clklvds(clklvds), .rstn(rstn), .samplevalue(samplevalue),
		.lvdsin_trig(lvdsin_trig), .lvdsin_trig_b(lvdsin_trig_b), .exttrigin(exttrigin),
		.lowerthresh(lowerthresh), .upperthresh(upperthresh),
		.lengthtotake(lengthtotake), .prelengthtotake(prelengthtotake),
		.triggerlive(triggerlive), .didreadout(didreadout), .triggertype(triggertype),
		.downsample(downsample), .downsamplemerging(downsamplemerging),
		.ram_wr(ram_wr), .ram_wr_address(ram_wr_address),
		.lvdsout_trig(lvdsout_trig), .lvdsout_trig_b(lvdsout_trig_b),
		.auxtrigout(auxtrigout), .led(led), .acq_state(acq_state),
		.event_count(event_count), .ram_address_triggered(ram_address_triggered)
	);

	initial begin
		clklvds = 1'b0;
		forever #50 clklvds = ~clklvds; // 100 ns period
	end

	function automatic int timeout_limit();
		int total;
		total = 200;
		for (int i = 0; i < N_TESTS; i++)
			total += (VECTORS[i].pre + VECTORS[i].post + 8) * (1 << VECTORS[i].ds)
				* VECTORS[i].merge;
		return total;
	endfunction

	// counts rising edges and stops a hung run
	initial begin
		cycle = 0;
		limit = timeout_limit();
		while (cycle < limit) begin
			@(posedge clklvds);
			cycle++;
		end
		$display("timeout after %0d cycles, acq_state %h", cycle, acq_state);
		$display("=== FAIL ===");
		$finish;
	end

	function automatic logic signed [SAMPLE_W-1:0] noise_sample();
		int r;
		r = int'($urandom % 101) - 50; // well inside -100 .. 100
		return r[SAMPLE_W-1:0];
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Fail %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic sample_outputs();
		check_value("led", 32'(led), 32'(exttrigin)); // combinational echo
		if (lvdsout_trig)
			fwd_cycles++;
		if (lvdsout_trig_b)
			bwd_cycles++;
		if (ram_wr && auxtrigout)
			aux_pulses++;
		if (ram_wr) begin
			exp_addr = exp_addr + 1'b1; // every strobe advances the ring
			check_value("ram_wr_address", 32'(ram_wr_address), 32'(exp_addr));
		end
		if (acq_state == ST_IDLE || acq_state == ST_DONE)
			last_pulse = -1; // capture window closed
		else if (ram_wr) begin
			if (last_pulse >= 0)
				check_value("ram_wr spacing", 32'(cycle - last_pulse), 32'(spacing));
			last_pulse = cycle;
		end
		if (acq_state == ST_POST && prev_state != ST_POST)
			check_value("ram_address_triggered", 32'(ram_address_triggered), 32'(prev_addr));
		prev_state = acq_state;
		prev_addr  = exp_addr;
	endtask

	task automatic drive_samples();
		for (int i = 0; i < N_LANES*LANE_SAMPLES; i++)
			samplevalue[i] = noise_sample();
		if (forced_level != 0)
			samplevalue[forced_lane*LANE_SAMPLES + 3] = forced_level; // the crossing sample
	endtask

	// look at the outputs on the falling edge and drive the next inputs
	task automatic step();
		@(negedge clklvds);
		sample_outputs();
		drive_samples();
	endtask

	task automatic wait_state(input acq_state_t st);
		while (acq_state != st)
			step();
	endtask

	task automatic hold_level(input logic signed [SAMPLE_W-1:0] level, input int n);
		forced_level = level;
		repeat (n) step();
	endtask

	task automatic apply_stimulus();
		forced_lane = v.lane;
		case (v.pattern)
			PAT_LOHI: begin
				hold_level(-12'sd500, 3); // arm below lower threshold
				hold_level(12'sd500, 4);
			end
			PAT_HILO: begin
				hold_level(12'sd500, 3);
				hold_level(-12'sd500, 4);
			end
			PAT_HI:  hold_level(12'sd500, 5);
			PAT_LO:  hold_level(-12'sd500, 5);
			default: ;
		endcase
		forced_level = '0;
		lvdsin_trig   = (v.pulse == PULSE_FWD);
		lvdsin_trig_b = (v.pulse == PULSE_BWD);
		exttrigin     = (v.pulse == PULSE_EXT);
		if (v.pulse != PULSE_NONE)
			step(); // single cycle pulse
		lvdsin_trig   = 1'b0;
		lvdsin_trig_b = 1'b0;
		exttrigin     = 1'b0;
	endtask

	initial begin
		void'($urandom(32'hf1e0));
		rstn              = 1'b0;
		lvdsin_trig       = 1'b0;
		lvdsin_trig_b     = 1'b0;
		exttrigin         = 1'b0;
		lowerthresh       = -12'sd100;
		upperthresh       = 12'sd100;
		lengthtotake      = '0;
		prelengthtotake   = '0;
		triggerlive       = 1'b0;
		didreadout        = 1'b0;
		triggertype       = TRIG_OFF;
		downsample        = '0;
		downsamplemerging = 8'd1;
		drive_samples();
		repeat (8) begin
			step();
			check_value("ram_wr", 32'(ram_wr), 0);
			check_value("lvdsout_trig", 32'(lvdsout_trig), 0);
			check_value("lvdsout_trig_b", 32'(lvdsout_trig_b), 0);
			check_value("auxtrigout", 32'(auxtrigout), 0);
			check_value("acq_state", 32'(acq_state), 32'(ST_IDLE));
			check_value("event_count", event_count, 0);
		end
		rstn = 1'b1;
		for (int t = 0; t < N_TESTS; t++) begin
			v = VECTORS[t];
			err_before        = errors;
			fwd_before        = fwd_cycles;
			bwd_before        = bwd_cycles;
			aux_before        = aux_pulses;
			spacing           = (1 << v.ds) * v.merge;
			downsample        = v.ds;
			downsamplemerging = v.merge;
			prelengthtotake   = v.pre;
			lengthtotake      = v.post;
			triggerlive       = 1'b1;
			step(); // settings land before the type arms the FSM
			triggertype = v.ttype;
			if (v.ttype == TRIG_OFF) begin
				repeat (16) begin
					step();
					check_value("acq_state", 32'(acq_state), 32'(ST_IDLE));
					check_value("ram_wr", 32'(ram_wr), 0);
				end
			end else begin
				step();
				while (acq_state == ST_IDLE || acq_state == ST_PRE)
					step();
				apply_stimulus();
				if (v.exp_event) begin
					wait_state(ST_DONE);
					repeat (3) begin
						step();
						check_value("acq_state", 32'(acq_state), 32'(ST_DONE)); // waits for read-out
					end
					didreadout  = 1'b1;
					triggertype = TRIG_OFF;
					wait_state(ST_IDLE);
					didreadout = 1'b0;
				end else begin
					repeat (16) begin
						step();
						assert (acq_state != ST_POST && acq_state != ST_DONE) else begin
							$display("trigger fired although none was expected");
							errors++;
						end
					end
					triggertype = TRIG_OFF; // abort from the wait state
					wait_state(ST_IDLE);
				end
			end
			step();
			step();
			exp_events = exp_events + 32'(v.exp_event);
			check_value("event_count", event_count, exp_events);
			check_value("lvdsout_trig cycles", 32'(fwd_cycles - fwd_before),
				v.exp_lvds[0] ? 2 : 0);
			check_value("lvdsout_trig_b cycles", 32'(bwd_cycles - bwd_before),
				v.exp_lvds[1] ? 2 : 0);
			if (v.exp_event)
				check_value("ram_wr in post", 32'(aux_pulses - aux_before), 32'(v.post));
			if (errors == err_before)
				passed++;
			else
				failed++;
			$display("test %0d type %0d ds %0d merge %0d: %s", t, v.ttype, v.ds, v.merge,
				(errors == err_before) ? "ok" : "failed");
		end
		$display("tests passed %0d failed %0d, check errors %0d", passed, failed, errors);
		if (failed == 0 && errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

/* project.f */
+incdir+sim
verilog/trig_pkg.sv
verilog/config_regs.sv
verilog/decimator.sv
verilog/threshold_lane.sv
verilog/acq_controller.sv
verilog/triggerer.sv
sim/tb_triggerer.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, pass only if the pass line appears
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_triggerer -f project.f -o tb_triggerer \
	&& ./obj_dir/tb_triggerer | tee /dev/stderr | grep -q "=== PASS ===" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
